//--- verilog.f
common/mist_pkg.sv
common/mem_req_if.sv
memory/mem_arbiter.sv
memory/mem_endian_port.sv
logic/io_bridge.sv
logic/mist_fabric_top.sv
dv/tb_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build tb_fabric with Verilator, run it, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fabric -f verilog.f > build.log 2>&1 &&
	./obj_dir/Vtb_fabric > sim.log 2>&1 ||
	echo "build or run stopped early, see build.log and sim.log"
grep -qs '^STATUS: PASS$' sim.log && echo "simulation result: pass" ||
	{ echo "simulation result: fail"; exit 1; }

//--- dv/tb_fabric.sv
// Testbench for mist_fabric_top with memory and GCI models; memory answers in order, 1 to 4 cycles
// Inputs change 2 units after each rising edge, outputs are sampled on the falling edge
`default_nettype none

module tb_fabric
	import mist_pkg::*;
();

	// Covers all tests with wide margin, worst case is well under 1000 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic iBUS_CLOCK;
	logic inRESET;
	logic inst_req, inst_lock, inst_valid;
	logic [ADDR_W-1:0] inst_addr;
	logic [RDATA_W-1:0] inst_data;
	logic data_req, data_lock, data_rw, data_valid;
	order_t data_order;
	logic [MASK_W-1:0] data_mask;
	logic [ADDR_W-1:0] data_addr;
	logic [DATA_W-1:0] data_data;
	logic [RDATA_W-1:0] data_rdata;
	logic memory_req, memory_lock, memory_rw, memory_valid;
	order_t memory_order;
	logic [MASK_W-1:0] memory_mask;
	logic [ADDR_W-1:0] memory_addr;
	logic [DATA_W-1:0] memory_data;
	logic [RDATA_W-1:0] memory_rdata;
	logic io_req, io_busy, io_rw, io_valid, io_fault;
	order_t io_order;
	logic [ADDR_W-1:0] io_addr;
	logic [DATA_W-1:0] io_data, io_rdata;
	logic gci_req, gci_busy, gci_rw, gci_rvalid;
	logic [ADDR_W-1:0] gci_addr;
	logic [DATA_W-1:0] gci_data, gci_rdata;

	// Scoreboard
	logic [RDATA_W-1:0] exp_inst_q[$];
	logic [RDATA_W-1:0] exp_data_q[$];
	logic [ADDR_W-1:0] wr_addr_q[$];
	logic [DATA_W-1:0] wr_data_q[$];
	logic [MASK_W-1:0] wr_mask_q[$];
	int checks = 0;
	int errors = 0;
	int cycle = 0;
	int reads_issued = 0;
	int reads_returned = 0;
	int peak = 0;
	int mark;

	// Memory and GCI model state
	logic lock_en = 1'b0;
	logic mem_take_rd, gci_take_rd, gci_seen;
	logic [ADDR_W-1:0] mem_take_addr, gci_take_addr, gci_hold;
	logic [ADDR_W-1:0] mem_pend_addr[$];
	int mem_pend_due[$];
	int last_due = 0;
	int due;
	int gci_wait = 0;

	mist_fabric_top u_dut (.*);

	initial begin
		iBUS_CLOCK = 1'b0;
		forever #20 iBUS_CLOCK = ~iBUS_CLOCK;
	end

	// Memory content, every address bit matters
	function automatic logic [RDATA_W-1:0] mem_pattern(input logic [ADDR_W-1:0] addr);
		return {addr ^ 32'hC3A5_5A3C, {addr[15:0], addr[31:16]} + 32'h1357_9BDF};
	endfunction

	function automatic logic [DATA_W-1:0] gci_pattern(input logic [ADDR_W-1:0] addr);
		return ~addr ^ 32'h2468_ACE0;
	endfunction

	function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] w);
		logic [DATA_W-1:0] r;
		int b;
		for (b = 0; b < 4; b++) begin
			r[8*b +: 8] = w[8*(3-b) +: 8];
		end
		return r;
	endfunction

	function automatic logic [MASK_W-1:0] reverse_mask(input logic [MASK_W-1:0] m);
		logic [MASK_W-1:0] r;
		int i;
		for (i = 0; i < MASK_W; i++) begin
			r[i] = m[MASK_W-1-i];
		end
		return r;
	endfunction

	// Read return as the core sees it, each word swapped on its own
	function automatic logic [RDATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
		logic [RDATA_W-1:0] raw;
		raw = mem_pattern(addr);
		return {swap_bytes(raw[63:32]), swap_bytes(raw[31:0])};
	endfunction

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %-10s %s, %0d errors", name, (errors == mark) ? "ok" : "failed",
			errors - mark);
		mark = errors;
	endtask

	// Holds the request until a falling edge sees the lock low
	task automatic issue_data(input logic rw, input logic [MASK_W-1:0] mask,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
		data_req = 1'b1;
		data_rw = rw;
		data_order = ORDER_WORD;
		data_mask = mask;
		data_addr = addr;
		data_data = wdata;
		@(negedge iBUS_CLOCK);
		while (data_lock) @(negedge iBUS_CLOCK);
		if (rw) begin
			wr_addr_q.push_back(addr);
			wr_data_q.push_back(swap_bytes(wdata));
			wr_mask_q.push_back(reverse_mask(mask));
		end else begin
			exp_data_q.push_back(expected_read(addr));
			reads_issued++;
		end
		@(posedge iBUS_CLOCK);
		#2;
	endtask

	task automatic inst_stream(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			inst_req = 1'b1;
			inst_addr = $urandom;
			@(negedge iBUS_CLOCK);
			while (inst_lock) @(negedge iBUS_CLOCK);
			exp_inst_q.push_back(expected_read(inst_addr));
			reads_issued++;
			@(posedge iBUS_CLOCK);
			#2;
		end
		inst_req = 1'b0;
	endtask

	task automatic data_stream(input int n, input logic mix_writes);
		int i;
		logic rw;
		for (i = 0; i < n; i++) begin
			rw = mix_writes && ($urandom % 3 == 0);
			issue_data(rw, MASK_W'($urandom), $urandom, $urandom);
		end
		data_req = 1'b0;
	endtask

	task automatic wait_drain();
		while (reads_returned != reads_issued) @(posedge iBUS_CLOCK);
		#2;
	endtask

	// Sample memory and GCI accepts where outputs are stable
	always @(negedge iBUS_CLOCK) begin
		mem_take_rd = memory_req && !memory_lock && !memory_rw;
		mem_take_addr = memory_addr;
		if (memory_req && !memory_lock && memory_rw) begin
			if (wr_addr_q.size() == 0) begin
				$display("Error at %0t: memory write seen but no write was issued", $time);
				errors++;
			end else begin
				check_value("write addr", 64'(memory_addr), 64'(wr_addr_q.pop_front()));
				check_value("write data", 64'(memory_data), 64'(wr_data_q.pop_front()));
				check_value("write mask", 64'(memory_mask), 64'(wr_mask_q.pop_front()));
			end
		end
		gci_take_rd = gci_req && !gci_rw;
		gci_take_addr = gci_addr;
		if (gci_req) gci_seen = 1'b1;
	end

	// Memory answers in order after 1 to 4 cycles, GCI after 2
	always begin
		@(posedge iBUS_CLOCK);
		#2;
		if (mem_take_rd) begin
			due = cycle + 1 + int'($urandom % 4);
			if (due <= last_due) due = last_due + 1;
			last_due = due;
			mem_pend_addr.push_back(mem_take_addr);
			mem_pend_due.push_back(due);
		end
		memory_valid = 1'b0;
		if (mem_pend_due.size() > 0 && mem_pend_due[0] == cycle) begin
			void'(mem_pend_due.pop_front());
			memory_valid = 1'b1;
			memory_rdata = mem_pattern(mem_pend_addr.pop_front());
		end
		memory_lock = lock_en && ($urandom % 3 == 0);
		gci_rvalid = 1'b0;
		if (gci_wait > 0) begin
			gci_wait--;
			if (gci_wait == 0) begin
				gci_rvalid = 1'b1;
				gci_rdata = gci_pattern(gci_hold);
			end
		end
		if (gci_take_rd) begin
			gci_wait = 2;
			gci_hold = gci_take_addr;
		end
	end

	// Every return against the oldest expected value of its port
	always @(negedge iBUS_CLOCK) begin
		if (inst_valid) begin
			reads_returned++;
			if (exp_inst_q.size() == 0) begin
				$display("Error at %0t: instruction return with no fetch outstanding", $time);
				errors++;
			end else begin
				check_value("inst return", inst_data, exp_inst_q.pop_front());
			end
		end
		if (data_valid) begin
			reads_returned++;
			if (exp_data_q.size() == 0) begin
				$display("Error at %0t: data return with no read outstanding", $time);
				errors++;
			end else begin
				check_value("data return", data_rdata, exp_data_q.pop_front());
			end
		end
	end

	// Timeout and the in-flight limit
	always @(posedge iBUS_CLOCK) begin
		cycle++;
		if (reads_issued - reads_returned > peak) peak = reads_issued - reads_returned;
		assert (reads_issued - reads_returned <= MEM_OUTSTANDING) else begin
			$display("Error at %0t: more than %0d reads in flight", $time, MEM_OUTSTANDING);
			errors++;
		end
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(71405));
		inRESET = 1'b0;
		inst_req = 1'b0;
		inst_addr = '0;
		data_req = 1'b0;
		data_order = ORDER_WORD;
		data_mask = '0;
		data_rw = 1'b0;
		data_addr = '0;
		data_data = '0;
		memory_lock = 1'b0;
		memory_valid = 1'b0;
		memory_rdata = '0;
		io_req = 1'b0;
		io_order = ORDER_WORD;
		io_rw = 1'b0;
		io_addr = '0;
		io_data = '0;
		gci_busy = 1'b0;
		gci_rvalid = 1'b0;
		gci_rdata = '0;
		gci_seen = 1'b0;
		mark = 0;
		repeat (5) @(posedge iBUS_CLOCK);
		#2;
		inRESET = 1'b1;
		@(negedge iBUS_CLOCK);
		check_value("reset outputs", 64'({memory_req, inst_valid, data_valid, io_valid,
			io_fault, gci_req}), 64'(0));
		finish_test("reset");
		@(posedge iBUS_CLOCK);
		#2;

		// Write reaches the bus one cycle after acceptance
		issue_data(1'b1, 4'b0011, 32'h0000_1238, 32'h1122_3344);
		data_req = 1'b0;
		@(negedge iBUS_CLOCK);
		check_value("memory_req", 64'(memory_req), 64'(1));
		check_value("memory_rw", 64'(memory_rw), 64'(1));
		check_value("memory_order", 64'(memory_order), 64'(ORDER_WORD));
		check_value("memory_data", 64'(memory_data), 64'(32'h4433_2211));
		check_value("memory_mask", 64'(memory_mask), 64'(4'b1100));
		finish_test("write");
		@(posedge iBUS_CLOCK);
		#2;

		// Both ports at once, no stalls
		fork
			inst_stream(6);
			data_stream(6, 1'b0);
		join
		wait_drain();
		finish_test("dual_read");

		// Random stalls with writes mixed in
		lock_en = 1'b1;
		fork
			inst_stream(12);
			data_stream(12, 1'b1);
		join
		wait_drain();
		lock_en = 1'b0;
		repeat (3) @(posedge iBUS_CLOCK);
		#2;
		check_value("writes left", 64'(wr_addr_q.size()), 64'(0));
		$display("test stall peak in flight %0d", peak);
		finish_test("stall");

		// IO write held off by GCI busy, then accepted
		io_req = 1'b1;
		io_rw = 1'b1;
		io_order = ORDER_WORD;
		io_addr = 32'h0000_0240;
		io_data = 32'hCAFE_0011;
		gci_busy = 1'b1;
		@(negedge iBUS_CLOCK);
		check_value("io busy", 64'({io_busy, gci_req}), 64'(2'b10));
		@(posedge iBUS_CLOCK);
		#2;
		gci_busy = 1'b0;
		@(negedge iBUS_CLOCK);
		check_value("no ack while busy", 64'(io_valid), 64'(0));
		check_value("gci write req", 64'({gci_req, gci_rw}), 64'(2'b11));
		check_value("gci write", 64'({gci_addr, gci_data}), {32'h0000_0240, 32'hCAFE_0011});
		@(posedge iBUS_CLOCK);
		#2;
		io_req = 1'b0;
		@(negedge iBUS_CLOCK);
		check_value("io write ack", 64'(io_valid), 64'(1));
		@(posedge iBUS_CLOCK);
		#2;
		io_req = 1'b1;
		io_rw = 1'b0;
		io_addr = 32'h0000_0380;
		@(negedge iBUS_CLOCK);
		check_value("gci read req", 64'(gci_req), 64'(1));
		@(posedge iBUS_CLOCK);
		#2;
		io_req = 1'b0;
		due = 0;
		@(negedge iBUS_CLOCK);
		while (!io_valid && due < 10) begin
			due++;
			@(negedge iBUS_CLOCK);
		end
		if (!io_valid) begin
			$display("Error at %0t: IO read never returned", $time);
			errors++;
		end else begin
			check_value("io read data", 64'(io_rdata), 64'(gci_pattern(32'h0000_0380)));
		end
		finish_test("io");
		@(posedge iBUS_CLOCK);
		#2;

		// Byte order faults and stays off GCI
		gci_seen = 1'b0;
		io_req = 1'b1;
		io_rw = 1'b1;
		io_order = ORDER_BYTE;
		@(negedge iBUS_CLOCK);
		check_value("gci_req on fault", 64'(gci_req), 64'(0));
		@(posedge iBUS_CLOCK);
		#2;
		io_req = 1'b0;
		@(negedge iBUS_CLOCK);
		check_value("io_fault", 64'({io_fault, io_valid}), 64'(2'b10));
		@(negedge iBUS_CLOCK);
		check_value("io_fault pulse", 64'(io_fault), 64'(0));
		check_value("gci never raised", 64'(gci_seen), 64'(0));
		finish_test("io_fault");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/mist_fabric_top.sv
// Memory and IO fabric of the processor top, everything on iBUS_CLOCK
// Memory reads return 64 bits; IO is word access only
`default_nettype none

module mist_fabric_top
	import mist_pkg::*;
(
	input wire logic iBUS_CLOCK,
	input wire logic inRESET,
	// Instruction fetch
	input wire logic inst_req,
	output logic inst_lock,
	input wire logic [ADDR_W-1:0] inst_addr,
	output logic inst_valid,
	output logic [RDATA_W-1:0] inst_data,
	// Data access
	input wire logic data_req,
	output logic data_lock,
	input wire order_t data_order,
	input wire logic [MASK_W-1:0] data_mask,
	input wire logic data_rw,
	input wire logic [ADDR_W-1:0] data_addr,
	input wire logic [DATA_W-1:0] data_data,
	output logic data_valid,
	output logic [RDATA_W-1:0] data_rdata,
	// External memory bus
	output logic memory_req,
	input wire logic memory_lock,
	output order_t memory_order,
	output logic [MASK_W-1:0] memory_mask,
	output logic memory_rw,
	output logic [ADDR_W-1:0] memory_addr,
	output logic [DATA_W-1:0] memory_data,
	input wire logic memory_valid,
	input wire logic [RDATA_W-1:0] memory_rdata,
	// Core IO
	input wire logic io_req,
	output logic io_busy,
	input wire order_t io_order,
	input wire logic io_rw,
	input wire logic [ADDR_W-1:0] io_addr,
	input wire logic [DATA_W-1:0] io_data,
	output logic io_valid,
	output logic io_fault,
	output logic [DATA_W-1:0] io_rdata,
	// GCI bus
	output logic gci_req,
	input wire logic gci_busy,
	output logic gci_rw,
	output logic [ADDR_W-1:0] gci_addr,
	output logic [DATA_W-1:0] gci_data,
	input wire logic gci_rvalid,
	input wire logic [DATA_W-1:0] gci_rdata
);

	// Arbiter to endian stage
	mem_req_if u_req_if ();

	// Read return into the arbiter
	logic rsp_valid;
	logic [RDATA_W-1:0] rsp_data;

	mem_arbiter u_arbiter (
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.inst_req(inst_req),
		.inst_lock(inst_lock),
		.inst_addr(inst_addr),
		.inst_valid(inst_valid),
		.inst_data(inst_data),
		.data_req(data_req),
		.data_lock(data_lock),
		.data_order(data_order),
		.data_mask(data_mask),
		.data_rw(data_rw),
		.data_addr(data_addr),
		.data_data(data_data),
		.data_valid(data_valid),
		.data_rdata(data_rdata),
		.bus(u_req_if.arbiter),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data)
	);

	mem_endian_port u_endian_port (
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.bus(u_req_if.port),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.memory_req(memory_req),
		.memory_lock(memory_lock),
		.memory_order(memory_order),
		.memory_mask(memory_mask),
		.memory_rw(memory_rw),
		.memory_addr(memory_addr),
		.memory_data(memory_data),
		.memory_valid(memory_valid),
		.memory_rdata(memory_rdata)
	);

	io_bridge u_io_bridge (
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.io_req(io_req),
		.io_busy(io_busy),
		.io_order(io_order),
		.io_rw(io_rw),
		.io_addr(io_addr),
		.io_data(io_data),
		.io_valid(io_valid),
		.io_fault(io_fault),
		.io_rdata(io_rdata),
		.gci_req(gci_req),
		.gci_busy(gci_busy),
		.gci_rw(gci_rw),
		.gci_addr(gci_addr),
		.gci_data(gci_data),
		.gci_rvalid(gci_rvalid),
		.gci_rdata(gci_rdata)
	);

endmodule

`default_nettype wire

//--- logic/io_bridge.sv
// Core IO to GCI; only word order is forwarded, any other order faults
// GCI gives no write response, so writes are acknowledged here one cycle on
`default_nettype none

module io_bridge
	import mist_pkg::*;
(
	input wire logic iBUS_CLOCK,
	input wire logic inRESET,
	// Core IO side
	input wire logic io_req,
	output logic io_busy,
	input wire order_t io_order,
	// 1 = write
	input wire logic io_rw,
	input wire logic [ADDR_W-1:0] io_addr,
	input wire logic [DATA_W-1:0] io_data,
	output logic io_valid,
	output logic io_fault,
	output logic [DATA_W-1:0] io_rdata,
	// GCI side
	output logic gci_req,
	input wire logic gci_busy,
	output logic gci_rw,
	output logic [ADDR_W-1:0] gci_addr,
	output logic [DATA_W-1:0] gci_data,
	input wire logic gci_rvalid,
	input wire logic [DATA_W-1:0] gci_rdata
);

	logic accept;
	logic is_word;
	logic write_ack;

	// GCI busy stalls the core directly
	assign io_busy = gci_busy;
	assign accept = io_req & ~gci_busy;
	assign is_word = (io_order == ORDER_WORD);

	// Forwarded in the accept cycle itself
	assign gci_req = accept & is_word;
	assign gci_rw = io_rw;
	assign gci_addr = io_addr;
	assign gci_data = io_data;

	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			write_ack <= 1'b0;
			io_fault <= 1'b0;
		end else begin
			// Faulted writes get the fault, not an ack
			write_ack <= accept & is_word & io_rw;
			// Byte, half and none orders are illegal on IO
			io_fault <= accept & ~is_word;
		end
	end

	// Read data comes from GCI, write completion from here
	assign io_valid = gci_rvalid | write_ack;
	assign io_rdata = gci_rdata;

	// One response kind per access
	a_ack_xor_fault: assert property (
		@(posedge iBUS_CLOCK) disable iff (!inRESET)
		!(write_ack && io_fault)
	);

endmodule

`default_nettype wire

//--- memory/mem_endian_port.sv
// One-entry request stage onto the memory bus, big-endian byte lanes on the bus side
// Stage is held whole while memory_lock is high with memory_req up
`default_nettype none

module mem_endian_port
	import mist_pkg::*;
(
	input wire logic iBUS_CLOCK,
	input wire logic inRESET,
	// From the arbiter
	mem_req_if.port bus,
	output logic rsp_valid,
	output logic [RDATA_W-1:0] rsp_data,
	// Memory bus
	output logic memory_req,
	input wire logic memory_lock,
	output order_t memory_order,
	output logic [MASK_W-1:0] memory_mask,
	output logic memory_rw,
	output logic [ADDR_W-1:0] memory_addr,
	output logic [DATA_W-1:0] memory_data,
	input wire logic memory_valid,
	input wire logic [RDATA_W-1:0] memory_rdata
);

	logic full;
	logic accept;

	// Payload of the held request
	order_t r_order;
	logic [MASK_W-1:0] r_mask;
	logic r_rw;
	logic [ADDR_W-1:0] r_addr;
	logic [DATA_W-1:0] r_data;

	// Stage frees up in the cycle the memory takes it
	assign bus.lock = full & memory_lock;
	assign accept = bus.req & ~bus.lock;

	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			full <= 1'b0;
		end else if (accept) begin
			full <= 1'b1;
		end else if (!memory_lock) begin
			full <= 1'b0;
		end
	end

	// Swap on entry so the bus sees stable registers
	always_ff @(posedge iBUS_CLOCK) begin
		if (accept) begin
			r_order <= bus.order;
			r_mask <= mask_swap(bus.mask);
			r_rw <= bus.rw;
			r_addr <= bus.addr;
			r_data <= byte_swap(bus.data);
		end
	end

	assign memory_req = full;
	assign memory_order = r_order;
	assign memory_mask = r_mask;
	assign memory_rw = r_rw;
	assign memory_addr = r_addr;
	assign memory_data = r_data;

	// Return path, one register stage
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= memory_valid;
		end
	end

	// Each 32-bit half swapped on its own
	always_ff @(posedge iBUS_CLOCK) begin
		rsp_data <= {byte_swap(memory_rdata[RDATA_W-1:DATA_W]),
			byte_swap(memory_rdata[DATA_W-1:0])};
	end

	// A stalled request may not change under the memory
	a_hold_on_lock: assert property (
		@(posedge iBUS_CLOCK) disable iff (!inRESET)
		(memory_req && memory_lock) |=>
			(memory_req && $stable({memory_order, memory_mask, memory_rw,
				memory_addr, memory_data}))
	);

endmodule

`default_nettype wire

//--- memory/mem_arbiter.sv
// Data port wins over instruction fetch; reads return in issue order only
// Instruction fetches always go out as full word reads
`default_nettype none

module mem_arbiter
	import mist_pkg::*;
(
	input wire logic iBUS_CLOCK,
	input wire logic inRESET,
	// Instruction fetch port
	input wire logic inst_req,
	output logic inst_lock,
	input wire logic [ADDR_W-1:0] inst_addr,
	output logic inst_valid,
	output logic [RDATA_W-1:0] inst_data,
	// Data port
	input wire logic data_req,
	output logic data_lock,
	input wire order_t data_order,
	input wire logic [MASK_W-1:0] data_mask,
	input wire logic data_rw,
	input wire logic [ADDR_W-1:0] data_addr,
	input wire logic [DATA_W-1:0] data_data,
	output logic data_valid,
	output logic [RDATA_W-1:0] data_rdata,
	// Toward the endian stage
	mem_req_if.arbiter bus,
	input wire logic rsp_valid,
	input wire logic [RDATA_W-1:0] rsp_data
);

	// Owner queue
	owner_t owner_q [MEM_OUTSTANDING];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] q_count;
	logic q_full;
	logic q_empty;

	logic accept;
	logic push;
	logic pop;
	owner_t push_owner;
	owner_t head_owner;

	assign q_full = (q_count == QCNT_W'(MEM_OUTSTANDING));
	assign q_empty = (q_count == '0);

	// Data blocks fetch outright
	assign inst_lock = bus.lock | data_req | q_full;
	// Writes never need a queue slot
	assign data_lock = bus.lock | (q_full & ~data_rw);

	// Request only when the chosen side could really be accepted
	always_comb begin
		if (data_req) begin
			bus.req = data_rw | ~q_full;
			bus.order = data_order;
			bus.mask = data_mask;
			bus.rw = data_rw;
			bus.addr = data_addr;
			bus.data = data_data;
		end else begin
			bus.req = inst_req & ~q_full;
			// Fetch is always a word read
			bus.order = ORDER_WORD;
			bus.mask = '1;
			bus.rw = 1'b0;
			bus.addr = inst_addr;
			bus.data = '0;
		end
	end

	assign accept = bus.req & ~bus.lock;
	assign push = accept & ~bus.rw;
	assign push_owner = data_req ? OWNER_DATA : OWNER_INST;
	assign pop = rsp_valid;

	// Owner storage, no reset needed
	always_ff @(posedge iBUS_CLOCK) begin
		if (push) begin
			owner_q[wr_ptr] <= push_owner;
		end
	end

	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + QPTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + QPTR_W'(1);
			end
			// Push and pop together leave the count alone
			case ({push, pop})
				2'b10: q_count <= q_count + QCNT_W'(1);
				2'b01: q_count <= q_count - QCNT_W'(1);
				default: q_count <= q_count;
			endcase
		end
	end

	// Steer the return by the oldest owner
	assign head_owner = owner_q[rd_ptr];
	assign inst_valid = rsp_valid & (head_owner == OWNER_INST);
	assign data_valid = rsp_valid & (head_owner == OWNER_DATA);
	assign inst_data = rsp_data;
	assign data_rdata = rsp_data;

	// Never more reads in flight than slots
	a_no_push_full: assert property (
		@(posedge iBUS_CLOCK) disable iff (!inRESET)
		push |-> !q_full
	);

	// Memory must not answer a read nobody issued
	a_no_rsp_empty: assert property (
		@(posedge iBUS_CLOCK) disable iff (!inRESET)
		rsp_valid |-> !q_empty
	);

endmodule

`default_nettype wire

//--- common/mem_req_if.sv
// Request path from the arbiter into the endian stage
// Accepted in any cycle with req high and lock low; no other handshake
`default_nettype none

interface mem_req_if
	import mist_pkg::*;
();

	logic req;
	logic lock;
	order_t order;
	logic [MASK_W-1:0] mask;
	// 1 = write, 0 = read
	logic rw;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;

	// Arbiter side drives the request
	modport arbiter (
		output req,
		output order,
		output mask,
		output rw,
		output addr,
		output data,
		input lock
	);

	// Endian stage pushes back with lock
	modport port (
		input req,
		input order,
		input mask,
		input rw,
		input addr,
		input data,
		output lock
	);

endinterface

`default_nettype wire

//--- common/mist_pkg.sv
// Shared widths, access codes and byte-order helpers for the memory and IO fabric
// Owner queue depth must stay a power of two, since its pointers wrap naturally
`default_nettype none

package mist_pkg;

	// Bus widths
	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int RDATA_W = 64;
	localparam int MASK_W  = 4;

	// Reads in flight between arbiter and memory
	localparam int MEM_OUTSTANDING = 4;
	localparam int QPTR_W = $clog2(MEM_OUTSTANDING);
	localparam int QCNT_W = $clog2(MEM_OUTSTANDING + 1);

	// Access size, same encoding as the core
	typedef enum logic [1:0] {
		ORDER_BYTE = 2'd0,
		ORDER_HALF = 2'd1,
		ORDER_WORD = 2'd2,
		ORDER_NONE = 2'd3
	} order_t;

	// Which port a read return belongs to
	typedef enum logic {
		OWNER_INST = 1'b0,
		OWNER_DATA = 1'b1
	} owner_t;

	// Byte 0 ends up in the top lane
	function automatic logic [DATA_W-1:0] byte_swap(input logic [DATA_W-1:0] word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	// Mask bits follow their bytes
	function automatic logic [MASK_W-1:0] mask_swap(input logic [MASK_W-1:0] mask);
		return {mask[0], mask[1], mask[2], mask[3]};
	endfunction

endpackage

`default_nettype wire
